// ==== src/tile_cfg_pkg.sv ====
// Tile address map and bus types, imported by the decoder and the register banks
package tile_cfg_pkg;

   localparam int ADDR_WIDTH = 32;
   localparam int DATA_WIDTH = 32;

   typedef logic [ADDR_WIDTH-1:0] addr_t;      // Bus byte address
   typedef logic [DATA_WIDTH-1:0] data_t;      // Bus data word
   typedef logic [ADDR_WIDTH-3:0] word_idx_t;  // Address without the byte offset

   // Distributed memory covers the lower half of the address space
   localparam int                     DM_MATCH_WIDTH = 1;
   localparam logic [DM_MATCH_WIDTH-1:0] DM_MATCH = 1'b0;

   // Network adapter registers live at 0xe000_0000 to 0xefff_ffff
   localparam int                     NA_MATCH_WIDTH = 4;
   localparam logic [NA_MATCH_WIDTH-1:0] NA_MATCH = 4'he;

   // Slave picked by the decoder for one access
   typedef enum logic [1:0] {
      SLAVE_DM,   // Distributed memory
      SLAVE_NA,   // Network adapter
      SLAVE_NONE  // No window matched
   } slave_sel_t;

endpackage

// ==== src/noc_pkg.sv ====
// NoC flit format and request/response records, imported by every pipeline stage
package noc_pkg;

   import tile_cfg_pkg::*;

   localparam int FLIT_WIDTH = 32;

   typedef logic [FLIT_WIDTH-1:0] flit_t;
   typedef logic [4:0]            node_id_t;  // Tile address on the NoC
   typedef logic [7:0]            tag_t;      // Request tag, echoed back

   typedef enum logic [1:0] {
      KIND_READ  = 2'd0,
      KIND_WRITE = 2'd1,
      KIND_RESP  = 2'd2
   } pkt_kind_t;

   // Header flit, MSB first
   typedef struct packed {
      node_id_t   dest;
      node_id_t   src;
      pkt_kind_t  kind;
      logic       status;  // Set on a decode error
      logic [10:0] rsvd;   // Always zero
      tag_t       tag;
   } noc_hdr_t;

   typedef struct packed {
      logic     write;
      addr_t    addr;
      data_t    wdata;
      node_id_t src;
      tag_t     tag;
   } bus_req_t;

   typedef struct packed {
      logic     write;
      logic     error;
      data_t    rdata;
      node_id_t dest;
      tag_t     tag;
   } bus_resp_t;

   typedef struct packed {
      flit_t flit;
      logic  last;
   } flit_in_t;

endpackage

// ==== src/credit_fifo.sv ====
// Circular buffer for any payload type, returns one credit to the sender per pop
`timescale 1ns/10ps

module credit_fifo #(
   parameter int  DEPTH     = 4,
   parameter type payload_t = logic [31:0]
) (
   input  logic     clk,
   input  logic     rst_i,
   input  logic     push_i,
   input  payload_t data_i,
   input  logic     pop_i,
   output payload_t data_o,
   output logic     valid_o,
   output logic     credit_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign valid_o = (count != '0);
   assign data_o  = mem[rd_ptr];           // Head is always visible
   assign do_pop  = pop_i && valid_o;

   always_ff @(posedge clk) begin
      if (push_i)
         mem[wr_ptr] <= data_i;             // Sender never overruns its credits
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         credit_o <= 1'b0;
      end else begin
         credit_o <= do_pop;                // One credit back per freed entry
         if (push_i)
            wr_ptr <= next_ptr(wr_ptr);
         if (do_pop)
            rd_ptr <= next_ptr(rd_ptr);
         case ({push_i, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;        // Both or neither
         endcase
      end
   end

endmodule

// ==== src/slave_reg_bank.sv ====
// Word-addressed register bank behind one decoder window, index wraps at the bank size
`timescale 1ns/10ps

module slave_reg_bank
   import tile_cfg_pkg::*;
#(
   parameter int WORDS = 16
) (
   input  logic      clk,
   input  logic      rst_i,
   input  logic      we_i,
   input  logic      re_i,
   input  word_idx_t word_i,
   input  data_t     wdata_i,
   output data_t     rdata_o
);

   localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;

   data_t            regs [WORDS];
   logic [IDX_W-1:0] idx;

   assign idx = IDX_W'(word_i % WORDS);  // Aliases repeat every WORDS words

   // Contents are architectural state and come up as zero
   always_ff @(posedge clk) begin
      if (rst_i) begin
         for (int i = 0; i < WORDS; i++)
            regs[i] <= '0;
      end else if (we_i) begin
         regs[idx] <= wdata_i;
      end
   end

   always_ff @(posedge clk) begin
      if (re_i)
         rdata_o <= regs[idx];             // One cycle read latency
   end

endmodule

// ==== src/noc_request_parser.sv ====
// First pipeline stage, assembles header, address and data flits into one bus request
`timescale 1ns/10ps

module noc_request_parser
   import noc_pkg::*;
(
   input  logic     clk,
   input  logic     rst_i,
   input  flit_t    flit_i,
   input  logic     last_i,
   input  logic     valid_i,
   output logic     pop_o,
   output logic     req_valid_o,
   output bus_req_t req_o,
   input  logic     req_accept_i
);

   localparam logic [1:0] IDX_HDR  = 2'd0;
   localparam logic [1:0] IDX_ADDR = 2'd1;
   localparam logic [1:0] IDX_DATA = 2'd2;

   noc_hdr_t   hdr;
   logic [1:0] flit_idx;  // Position of the next flit in the packet

   assign hdr = noc_hdr_t'(flit_i);

   // Flits are taken only while the hold register is free
   assign pop_o = valid_i && !req_valid_o;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         flit_idx    <= IDX_HDR;
         req_valid_o <= 1'b0;
      end else begin
         if (req_valid_o && req_accept_i)
            req_valid_o <= 1'b0;            // Decoder took it
         if (pop_o) begin
            if (last_i) begin
               flit_idx    <= IDX_HDR;
               req_valid_o <= 1'b1;         // Request complete
            end else if (flit_idx != IDX_DATA) begin
               flit_idx <= flit_idx + 1'b1;
            end
         end
      end
   end

   // Request fields fill in as their flits arrive
   always_ff @(posedge clk) begin
      if (pop_o) begin
         case (flit_idx)
            IDX_HDR: begin
               req_o.write <= (hdr.kind == KIND_WRITE);
               req_o.src   <= hdr.src;
               req_o.tag   <= hdr.tag;
               req_o.wdata <= '0;           // Reads carry no data flit
            end
            IDX_ADDR: begin
               req_o.addr <= flit_i;
            end
            default: begin
               req_o.wdata <= flit_i;
            end
         endcase
      end
   end

endmodule

// ==== src/bus_decoder.sv ====
// Second pipeline stage, selects a slave window, performs the access, forms the response
`timescale 1ns/10ps

module bus_decoder
   import tile_cfg_pkg::*;
   import noc_pkg::*;
#(
   parameter int DM_WORDS   = 16,
   parameter int NA_WORDS   = 8,
   parameter int RESP_DEPTH = 2
) (
   input  logic      clk,
   input  logic      rst_i,
   input  logic      req_valid_i,
   input  bus_req_t  req_i,
   output logic      req_accept_o,
   output logic      resp_push_o,
   output bus_resp_t resp_o,
   input  logic      resp_credit_i
);

   localparam int CRED_W = $clog2(RESP_DEPTH + 1);

   logic [CRED_W-1:0] credits;   // Free response buffer entries
   slave_sel_t        sel;
   slave_sel_t        sel_q;
   logic              write_q;
   node_id_t          dest_q;
   tag_t              tag_q;
   word_idx_t         word;
   data_t             dm_rdata;
   data_t             na_rdata;
   logic              dm_sel;
   logic              na_sel;

   always_comb begin
      if (req_i.addr[ADDR_WIDTH-1 -: DM_MATCH_WIDTH] == DM_MATCH)
         sel = SLAVE_DM;
      else if (req_i.addr[ADDR_WIDTH-1 -: NA_MATCH_WIDTH] == NA_MATCH)
         sel = SLAVE_NA;
      else
         sel = SLAVE_NONE;
   end

   assign req_accept_o = req_valid_i && (credits != '0);
   assign word         = req_i.addr[ADDR_WIDTH-1:2];
   assign dm_sel       = req_accept_o && (sel == SLAVE_DM);
   assign na_sel       = req_accept_o && (sel == SLAVE_NA);

   slave_reg_bank #(.WORDS(DM_WORDS)) u_dm_bank (
      .clk     (clk),
      .rst_i   (rst_i),
      .we_i    (dm_sel && req_i.write),
      .re_i    (dm_sel && !req_i.write),
      .word_i  (word),
      .wdata_i (req_i.wdata),
      .rdata_o (dm_rdata)
   );

   slave_reg_bank #(.WORDS(NA_WORDS)) u_na_bank (
      .clk     (clk),
      .rst_i   (rst_i),
      .we_i    (na_sel && req_i.write),
      .re_i    (na_sel && !req_i.write),
      .word_i  (word),
      .wdata_i (req_i.wdata),
      .rdata_o (na_rdata)
   );

   always_ff @(posedge clk) begin
      if (rst_i) begin
         credits     <= CRED_W'(RESP_DEPTH);
         resp_push_o <= 1'b0;
      end else begin
         resp_push_o <= req_accept_o;       // Bank read data ready next cycle
         case ({req_accept_o, resp_credit_i})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   // Request fields delayed to meet the registered bank read
   always_ff @(posedge clk) begin
      if (req_accept_o) begin
         sel_q   <= sel;
         write_q <= req_i.write;
         dest_q  <= req_i.src;
         tag_q   <= req_i.tag;
      end
   end

   always_comb begin
      resp_o.write = write_q;
      resp_o.error = (sel_q == SLAVE_NONE);
      resp_o.dest  = dest_q;
      resp_o.tag   = tag_q;
      if (write_q)
         resp_o.rdata = '0;
      else if (sel_q == SLAVE_DM)
         resp_o.rdata = dm_rdata;
      else if (sel_q == SLAVE_NA)
         resp_o.rdata = na_rdata;
      else
         resp_o.rdata = '0;                 // Unmapped reads return zero
   end

endmodule

// ==== src/noc_response_builder.sv ====
// Last pipeline stage, turns response records into NoC packets under output credit
`timescale 1ns/10ps

module noc_response_builder
   import tile_cfg_pkg::*;
   import noc_pkg::*;
#(
   parameter int       OUT_CREDITS = 2,
   parameter node_id_t TILE_ID     = 5'd3
) (
   input  logic      clk,
   input  logic      rst_i,
   input  bus_resp_t resp_i,
   input  logic      resp_valid_i,
   output logic      resp_pop_o,
   output flit_t     flit_o,
   output logic      last_o,
   output logic      valid_o,
   input  logic      credit_i
);

   localparam int CRED_W = $clog2(OUT_CREDITS + 1);

   logic [CRED_W-1:0] credits;
   logic              full_q;        // Output flit register occupied
   logic              data_pending;  // Read data flit still to follow
   data_t             data_q;
   logic              load;
   noc_hdr_t          hdr;

   always_comb begin
      hdr.dest   = resp_i.dest;       // Back to the requester
      hdr.src    = TILE_ID;
      hdr.kind   = KIND_RESP;
      hdr.status = resp_i.error;
      hdr.rsvd   = '0;
      hdr.tag    = resp_i.tag;
   end

   assign valid_o    = full_q && (credits != '0);
   assign load       = !full_q || valid_o;
   assign resp_pop_o = load && !data_pending && resp_valid_i;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         credits      <= CRED_W'(OUT_CREDITS);
         full_q       <= 1'b0;
         data_pending <= 1'b0;
      end else begin
         credits <= credits - CRED_W'(valid_o) + CRED_W'(credit_i);
         if (load) begin
            if (data_pending) begin
               full_q       <= 1'b1;
               data_pending <= 1'b0;
            end else if (resp_valid_i) begin
               full_q       <= 1'b1;
               data_pending <= !resp_i.write && !resp_i.error;
            end else begin
               full_q <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load && data_pending) begin
         flit_o <= data_q;
         last_o <= 1'b1;
      end else if (resp_pop_o) begin
         flit_o <= flit_t'(hdr);
         last_o <= resp_i.write || resp_i.error;  // Header-only packet
         data_q <= resp_i.rdata;
      end
   end

endmodule

// ==== src/compute_tile_top.sv ====
// Tile top, chains input buffer, parser, decoder, response buffer and builder
`timescale 1ns/10ps

module compute_tile_top
   import noc_pkg::*;
#(
   parameter int       IN_DEPTH    = 4,
   parameter int       RESP_DEPTH  = 2,
   parameter int       OUT_CREDITS = 2,
   parameter int       DM_WORDS    = 16,
   parameter int       NA_WORDS    = 8,
   parameter node_id_t TILE_ID     = 5'd3
) (
   input  logic  clk,
   input  logic  rst_i,
   input  flit_t noc_in_flit_i,
   input  logic  noc_in_last_i,
   input  logic  noc_in_valid_i,
   output logic  noc_in_credit_o,
   output flit_t noc_out_flit_o,
   output logic  noc_out_last_o,
   output logic  noc_out_valid_o,
   input  logic  noc_out_credit_i
);

   flit_in_t  in_word;
   flit_in_t  in_head;
   logic      in_valid;
   logic      in_pop;
   logic      req_valid;
   logic      req_accept;
   bus_req_t  req;
   logic      resp_push;
   bus_resp_t resp_in;
   bus_resp_t resp_head;
   logic      resp_valid;
   logic      resp_pop;
   logic      resp_credit;

   assign in_word = '{flit: noc_in_flit_i, last: noc_in_last_i};

   credit_fifo #(.DEPTH(IN_DEPTH), .payload_t(flit_in_t)) u_in_fifo (
      .clk(clk), .rst_i(rst_i), .push_i(noc_in_valid_i), .data_i(in_word),
      .pop_i(in_pop), .data_o(in_head), .valid_o(in_valid), .credit_o(noc_in_credit_o)
   );

   noc_request_parser u_parser (
      .clk(clk), .rst_i(rst_i), .flit_i(in_head.flit), .last_i(in_head.last),
      .valid_i(in_valid), .pop_o(in_pop), .req_valid_o(req_valid), .req_o(req),
      .req_accept_i(req_accept)
   );

   bus_decoder #(.DM_WORDS(DM_WORDS), .NA_WORDS(NA_WORDS), .RESP_DEPTH(RESP_DEPTH)) u_decoder (
      .clk(clk), .rst_i(rst_i), .req_valid_i(req_valid), .req_i(req),
      .req_accept_o(req_accept), .resp_push_o(resp_push), .resp_o(resp_in),
      .resp_credit_i(resp_credit)
   );

   credit_fifo #(.DEPTH(RESP_DEPTH), .payload_t(bus_resp_t)) u_resp_fifo (
      .clk(clk), .rst_i(rst_i), .push_i(resp_push), .data_i(resp_in),
      .pop_i(resp_pop), .data_o(resp_head), .valid_o(resp_valid), .credit_o(resp_credit)
   );

   noc_response_builder #(.OUT_CREDITS(OUT_CREDITS), .TILE_ID(TILE_ID)) u_builder (
      .clk(clk), .rst_i(rst_i), .resp_i(resp_head), .resp_valid_i(resp_valid),
      .resp_pop_o(resp_pop), .flit_o(noc_out_flit_o), .last_o(noc_out_last_o),
      .valid_o(noc_out_valid_o), .credit_i(noc_out_credit_i)
   );

endmodule

// ==== bench/tile_properties.sv ====
// Credit and reset protocol checks on the tile boundary, attached to compute_tile_top by bind
`timescale 1ns/10ps

module tile_properties #(
   parameter int IN_DEPTH    = 4,
   parameter int OUT_CREDITS = 2
) (
   input logic clk,
   input logic rst_i,
   input logic in_valid_i,
   input logic in_credit_i,
   input logic out_valid_i,
   input logic out_credit_i
);

   int in_outstanding;   // Flits sent but not yet credited back
   int out_avail;        // Credits the builder may still spend
   int fail_count = 0;

   always @(posedge clk) begin
      if (rst_i) begin
         in_outstanding <= 0;
         out_avail      <= OUT_CREDITS;
      end else begin
         in_outstanding <= in_outstanding + int'(in_valid_i) - int'(in_credit_i);
         out_avail      <= out_avail - int'(out_valid_i) + int'(out_credit_i);
      end
   end

   // Builder never sends without a credit in hand
   assert property (@(posedge clk) disable iff (rst_i) out_valid_i |-> (out_avail > 0))
      else begin
         fail_count++;
         $error("Output flit sent while no output credit was available");
      end

   // Boundary outputs quiet right after reset
   assert property (@(posedge clk) rst_i |=> (!out_valid_i && !in_credit_i))
      else begin
         fail_count++;
         $error("Output valid or input credit high in the cycle after reset");
      end

   assert property (@(posedge clk) disable iff (rst_i) in_outstanding <= IN_DEPTH)
      else begin
         fail_count++;
         $error("More input flits outstanding than the input buffer holds");
      end

endmodule

bind compute_tile_top tile_properties #(
   .IN_DEPTH    (IN_DEPTH),
   .OUT_CREDITS (OUT_CREDITS)
) u_props (
   .clk          (clk),
   .rst_i        (rst_i),
   .in_valid_i   (noc_in_valid_i),
   .in_credit_i  (noc_in_credit_o),
   .out_valid_i  (noc_out_valid_o),
   .out_credit_i (noc_out_credit_i)
);

// ==== bench/tb_compute_tile.sv ====
// Testbench for compute_tile_top, sends request packets under credit and checks every response
`timescale 1ns/10ps

module tb_compute_tile;

   localparam int         IN_DEPTH    = 4;
   localparam int         RESP_DEPTH  = 2;
   localparam int         OUT_CREDITS = 2;
   localparam int         DM_WORDS    = 16;
   localparam int         NA_WORDS    = 8;
   localparam logic [4:0] TILE_ID     = 5'd3;
   localparam logic [1:0] K_READ      = 2'd0;
   localparam logic [1:0] K_WRITE     = 2'd1;
   localparam logic [1:0] K_RESP      = 2'd2;
   localparam int         NUM_REQ     = 27;
   localparam int         TIMEOUT_CYCLES = 40 * NUM_REQ + 200;

   typedef struct packed {
      logic [31:0] hdr;
      logic        has_data;  // Successful read carries a data flit
      logic [31:0] data;
   } exp_t;

   logic        clk;
   logic        rst_i;
   logic [31:0] noc_in_flit_i;
   logic        noc_in_last_i;
   logic        noc_in_valid_i;
   logic        noc_in_credit_o;
   logic [31:0] noc_out_flit_o;
   logic        noc_out_last_o;
   logic        noc_out_valid_o;
   logic        noc_out_credit_i;

   exp_t        exp_q[$];
   exp_t        cur;
   logic [31:0] dm_model [int];
   logic [31:0] na_model [int];
   logic [7:0]  next_tag = 8'h10;
   logic        in_data = 1'b0;   // Waiting for the data flit of cur
   int          sent_cnt = 0;
   int          ret_cnt = 0;
   int          tx_count = 0;
   int          rx_done = 0;
   int          errors = 0;
   int          cycles = 0;
   int          hold_until = 0;   // No output credits before this cycle
   int          owed = 0;         // Output credits still to hand back

   compute_tile_top #(
      .IN_DEPTH(IN_DEPTH), .RESP_DEPTH(RESP_DEPTH), .OUT_CREDITS(OUT_CREDITS),
      .DM_WORDS(DM_WORDS), .NA_WORDS(NA_WORDS), .TILE_ID(TILE_ID)
   ) uut (
      .clk(clk), .rst_i(rst_i), .noc_in_flit_i(noc_in_flit_i), .noc_in_last_i(noc_in_last_i),
      .noc_in_valid_i(noc_in_valid_i), .noc_in_credit_o(noc_in_credit_o),
      .noc_out_flit_o(noc_out_flit_o), .noc_out_last_o(noc_out_last_o),
      .noc_out_valid_o(noc_out_valid_o), .noc_out_credit_i(noc_out_credit_i)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (rst_i)
         ret_cnt <= 0;
      else if (noc_in_credit_o)
         ret_cnt <= ret_cnt + 1;             // Input entry freed
   end

   // Receiver side, returns one credit per flit after a random delay
   always @(posedge clk) begin
      if (rst_i) begin
         owed = 0;
         noc_out_credit_i <= 1'b0;
      end else begin
         if (noc_out_valid_o)
            owed = owed + 1;
         if (cycles >= hold_until && owed > 0 && ($urandom % 3) != 0) begin
            owed = owed - 1;
            noc_out_credit_i <= 1'b1;
         end else begin
            noc_out_credit_i <= 1'b0;
         end
      end
   end

   always @(posedge clk) begin
      if (rst_i) begin
         in_data = 1'b0;
      end else if (noc_out_valid_o && !in_data) begin
         assert (exp_q.size() != 0)
            else begin
               errors++;
               $display("ERROR at %0t: header %h arrived with no request outstanding",
                        $time, noc_out_flit_o);
            end
         if (exp_q.size() != 0) begin
            cur = exp_q.pop_front();
            assert (noc_out_flit_o == cur.hdr)
               else begin
                  errors++;
                  $display("ERROR at %0t: header %h, expected %h", $time, noc_out_flit_o, cur.hdr);
               end
            assert (noc_out_last_o == !cur.has_data)
               else begin
                  errors++;
                  $display("ERROR at %0t: header last flag %b, expected %b",
                           $time, noc_out_last_o, !cur.has_data);
               end
            if (cur.has_data)
               in_data = 1'b1;
            else
               rx_done <= rx_done + 1;
         end
      end else if (noc_out_valid_o) begin
         assert (noc_out_flit_o == cur.data && noc_out_last_o)
            else begin
               errors++;
               $display("ERROR at %0t: data flit %h last %b, expected %h last 1",
                        $time, noc_out_flit_o, noc_out_last_o, cur.data);
            end
         in_data = 1'b0;
         rx_done <= rx_done + 1;
      end
   end

   function automatic void clear_model;
      for (int i = 0; i < DM_WORDS; i++)
         dm_model[i] = '0;
      for (int i = 0; i < NA_WORDS; i++)
         na_model[i] = '0;
   endfunction

   task automatic send_flit(input logic [31:0] flit, input logic last);
      @(posedge clk);
      while (IN_DEPTH - sent_cnt + ret_cnt <= 0) begin
         noc_in_valid_i <= 1'b0;             // Out of input credit
         @(posedge clk);
      end
      noc_in_flit_i  <= flit;
      noc_in_last_i  <= last;
      noc_in_valid_i <= 1'b1;
      sent_cnt++;
   endtask

   // Predicts the response from the address map, then sends the packet
   task automatic do_request(input logic wr, input logic [31:0] addr, input logic [31:0] wdata);
      exp_t       e;
      logic [4:0] src;
      logic [7:0] tag;
      logic       err;
      int         idx;
      tag = next_tag;
      src = 5'(next_tag * 3 + 1);
      next_tag = next_tag + 8'd1;
      err = 1'b0;
      e.has_data = 1'b0;
      e.data = '0;
      if (addr[31] == 1'b0) begin
         idx = int'((addr >> 2) % DM_WORDS);
         if (wr)
            dm_model[idx] = wdata;
         else
            e.data = dm_model[idx];
         e.has_data = !wr;
      end else if (addr[31:28] == 4'he) begin
         idx = int'((addr >> 2) % NA_WORDS);
         if (wr)
            na_model[idx] = wdata;
         else
            e.data = na_model[idx];
         e.has_data = !wr;
      end else begin
         err = 1'b1;
      end
      e.hdr = {src, TILE_ID, K_RESP, err, 11'b0, tag};
      exp_q.push_back(e);
      tx_count++;
      send_flit({TILE_ID, src, wr ? K_WRITE : K_READ, 1'b0, 11'b0, tag}, 1'b0);
      send_flit(addr, !wr);
      if (wr)
         send_flit(wdata, 1'b1);
   endtask

   task automatic wait_responses;
      @(posedge clk);
      noc_in_valid_i <= 1'b0;
      while (rx_done != tx_count)
         @(posedge clk);
   endtask

   task automatic apply_reset;
      wait_responses();
      @(posedge clk);
      rst_i <= 1'b1;
      repeat (2) @(posedge clk);
      rst_i <= 1'b0;
      sent_cnt = 0;
      clear_model();
   endtask

   initial begin
      void'($urandom(32'h7e2b));
      rst_i = 1'b1;
      noc_in_flit_i = '0;
      noc_in_last_i = 1'b0;
      noc_in_valid_i = 1'b0;
      noc_out_credit_i = 1'b0;
      clear_model();
      repeat (2) @(posedge clk);
      rst_i <= 1'b0;
      do_request(1'b1, 32'h0000_0010, 32'hcafe_0001);   // DM write, then read back
      do_request(1'b0, 32'h0000_0010, '0);
      do_request(1'b1, 32'he000_0010, 32'h5a5a_0004);   // NA word 4 beside DM word 4
      do_request(1'b1, 32'he000_0024, 32'h0bad_0009);
      do_request(1'b0, 32'h0000_0010, '0);
      do_request(1'b0, 32'he000_0010, '0);
      do_request(1'b0, 32'h0000_0050, '0);              // Word 20 wraps to 4
      do_request(1'b0, 32'he000_0030, '0);              // Word 12 wraps to 4
      do_request(1'b0, 32'he000_0004, '0);
      do_request(1'b0, 32'h9000_0000, '0);              // Unmapped accesses
      do_request(1'b1, 32'hf000_0010, 32'hdead_beef);
      do_request(1'b0, 32'h0000_0010, '0);
      do_request(1'b0, 32'he000_0010, '0);
      wait_responses();
      hold_until <= cycles + 120;                       // Long credit stall
      for (int i = 0; i < 6; i++)
         do_request(1'b1, 32'h0000_0020 + 32'(4 * i), $urandom);
      for (int i = 0; i < 6; i++)
         do_request(1'b0, 32'h0000_0020 + 32'(4 * i), '0);
      apply_reset();
      do_request(1'b0, 32'h0000_0010, '0);
      do_request(1'b0, 32'he000_0010, '0);
      wait_responses();
      $display("Checks finished: %0d errors, %0d property failures, %0d of %0d responses",
               errors, uut.u_props.fail_count, rx_done, tx_count);
      if (errors == 0 && uut.u_props.fail_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   initial begin
      while (cycles < TIMEOUT_CYCLES)
         @(posedge clk);
      $display("Run timed out after %0d cycles with %0d of %0d responses received",
               cycles, rx_done, tx_count);
      $display("Done: errors found");
      $finish;
   end

endmodule

// ==== sim.f ====
src/tile_cfg_pkg.sv
src/noc_pkg.sv
src/credit_fifo.sv
src/slave_reg_bank.sv
src/noc_request_parser.sv
src/bus_decoder.sv
src/noc_response_builder.sv
src/compute_tile_top.sv
bench/tile_properties.sv
bench/tb_compute_tile.sv

// ==== Makefile ====
# Verilator build and run for the compute tile testbench

VERILATOR ?= verilator
TOP       ?= tb_compute_tile
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
PASS_MSG  ?= Done: no errors

SOURCES := $(wildcard src/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
